//--- design/nbf_loader_cfg.svh
// Loader configuration macros for buffer size, bus widths, credit limit and control opcodes
`ifndef NBF_LOADER_CFG_SVH
`define NBF_LOADER_CFG_SVH

// Packet buffer geometry
`define NBF_DEPTH 256
`define NBF_IDX_W 8

// Memory-mapped I/O bus widths
`define NBF_ADDR_W 32
`define NBF_DATA_W 64

// Outstanding command limit and counter width
`define NBF_MAX_CREDITS 4
`define NBF_CREDIT_W 3

// Control opcodes decoded from the whole opcode byte
`define NBF_OP_FENCE 8'hFE
`define NBF_OP_FINISH 8'hFF

`endif

//--- design/nbf_loader_pkg.sv
// Loader types for packets, opcode views, transfer sizes and sequencer states
`include "nbf_loader_cfg.svh"

package nbf_loader_pkg;

  // Log2 coded transfer size in bytes
  typedef enum logic [1:0]
  {
    e_size_1 = 2'd0
    ,e_size_2 = 2'd1
    ,e_size_4 = 2'd2
    ,e_size_8 = 2'd3
  } nbf_size_e;

  // Opcode byte read either as a control code or as a memory opcode
  typedef union packed
  {
    logic [7:0] ctrl;
    struct packed
    {
      logic [4:0] rsvd;
      logic       rd;   // Set for uncached read
      nbf_size_e  size;
    } mem;
  } nbf_opcode_u;

  typedef struct packed
  {
    nbf_opcode_u             opcode;
    logic [`NBF_ADDR_W-1:0]  addr;
    logic [`NBF_DATA_W-1:0]  data;
  } nbf_packet_s;

  typedef enum logic [2:0]
  {
    e_idle
    ,e_send
    ,e_fence
    ,e_read
    ,e_done
  } nbf_state_e;

endpackage

//--- design/nbf_cmd_if.sv
// Command and status bundle between the packet sequencer and the I/O port
`timescale 1ns/1ps

interface nbf_cmd_if;
  import nbf_loader_pkg::*;

  logic        cmd_v;          // Current packet is a store or read
  nbf_packet_s cmd_pkt;
  logic        cmd_yumi;       // Command taken on the bus this cycle
  logic        credits_empty;  // Nothing outstanding
  logic        read_done;      // Read response seen

  modport seq
  (
    output cmd_v
    ,output cmd_pkt
    ,input cmd_yumi
    ,input credits_empty
    ,input read_done
  );

  modport io
  (
    input cmd_v
    ,input cmd_pkt
    ,output cmd_yumi
    ,output credits_empty
    ,output read_done
  );

endinterface

//--- design/nbf_program_buffer.sv
// Packet storage for the loader program, written by port and read by packet index
`timescale 1ns/1ps
`include "nbf_loader_cfg.svh"

module nbf_program_buffer
(
  input                               clk_i
  ,input                              we_i
  ,input        [`NBF_IDX_W-1:0]      waddr_i
  ,input        nbf_loader_pkg::nbf_packet_s wpkt_i
  ,input        [`NBF_IDX_W-1:0]      raddr_i
  ,output       nbf_loader_pkg::nbf_packet_s rpkt_o
);

  import nbf_loader_pkg::*;

  nbf_packet_s mem_r [`NBF_DEPTH];

  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      mem_r[waddr_i] <= wpkt_i;
    end
  end

  // Asynchronous read of the current packet
  assign rpkt_o = mem_r[raddr_i];

endmodule

//--- design/nbf_sequencer.sv
// Packet sequencer that walks the program and sends, fences, waits on reads and finishes
`timescale 1ns/1ps
`include "nbf_loader_cfg.svh"

module nbf_sequencer
(
  input                               clk_i
  ,input                              reset_i
  ,input                              start_i
  ,input        nbf_loader_pkg::nbf_packet_s pkt_i
  ,output logic [`NBF_IDX_W-1:0]      idx_o
  ,output logic                       done_o
  ,nbf_cmd_if.seq                     cmd
);

  import nbf_loader_pkg::*;

  nbf_state_e             state_r;
  nbf_state_e             state_n;
  logic [`NBF_IDX_W-1:0]  idx_r;
  logic                   is_send;
  logic                   is_fence_pkt;
  logic                   is_finish_pkt;
  logic                   is_mem_pkt;
  logic                   advance;

  assign is_send       = (state_r == e_send);
  assign is_fence_pkt  = (pkt_i.opcode.ctrl == `NBF_OP_FENCE);
  assign is_finish_pkt = (pkt_i.opcode.ctrl == `NBF_OP_FINISH);
  assign is_mem_pkt    = ~is_fence_pkt & ~is_finish_pkt;

  // Command wants out only while sending a store or read
  assign cmd.cmd_v   = is_send & is_mem_pkt;
  assign cmd.cmd_pkt = pkt_i;

  assign advance = is_send & (is_fence_pkt | is_finish_pkt | (is_mem_pkt & cmd.cmd_yumi));

  always_comb
  begin
    state_n = state_r;
    unique case (state_r)
      e_idle:
      begin
        if (start_i)
        begin
          state_n = e_send;
        end
      end
      e_send:
      begin
        if (is_fence_pkt)
        begin
          state_n = e_fence;
        end
        else if (is_finish_pkt)
        begin
          state_n = e_done;
        end
        else if (cmd.cmd_yumi && pkt_i.opcode.mem.rd)
        begin
          state_n = e_read;  // Hold until the read comes back
        end
      end
      e_fence:
      begin
        if (cmd.credits_empty)
        begin
          state_n = e_send;
        end
      end
      e_read:
      begin
        if (cmd.read_done)
        begin
          state_n = e_send;
        end
      end
      e_done:  state_n = e_done;
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_idle;
      idx_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (advance)
      begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  assign idx_o  = idx_r;
  assign done_o = (state_r == e_done);

endmodule

//--- design/nbf_io_port.sv
// I/O port that counts credits, gates command valid and checks read responses
`timescale 1ns/1ps
`include "nbf_loader_cfg.svh"

module nbf_io_port
(
  input                               clk_i
  ,input                              reset_i
  ,input                              io_cmd_yumi_i
  ,input                              io_resp_v_i
  ,input                              io_resp_read_i
  ,input        [`NBF_DATA_W-1:0]     io_resp_data_i
  ,output logic                       io_cmd_v_o
  ,output logic                       io_cmd_read_o
  ,output       nbf_loader_pkg::nbf_size_e io_cmd_size_o
  ,output logic [`NBF_ADDR_W-1:0]     io_cmd_addr_o
  ,output logic [`NBF_DATA_W-1:0]     io_cmd_data_o
  ,output logic [7:0]                 mismatch_count_o
  ,nbf_cmd_if.io                      cmd
);

  import nbf_loader_pkg::*;

  logic [`NBF_CREDIT_W-1:0] credit_count_r;
  logic                     credits_full;
  logic                     cmd_take;
  logic                     read_resp;
  logic [`NBF_DATA_W-1:0]   exp_data_r;
  nbf_size_e                exp_size_r;
  logic [`NBF_DATA_W-1:0]   byte_mask;
  logic                     data_diff;
  logic [7:0]               mismatch_count_r;

  assign credits_full = (credit_count_r == `NBF_MAX_CREDITS);
  assign io_cmd_v_o   = cmd.cmd_v & ~credits_full;  // Held off at the credit limit
  assign cmd_take     = io_cmd_v_o & io_cmd_yumi_i;

  assign io_cmd_read_o = cmd.cmd_pkt.opcode.mem.rd;
  assign io_cmd_size_o = cmd.cmd_pkt.opcode.mem.size;
  assign io_cmd_addr_o = cmd.cmd_pkt.addr;
  assign io_cmd_data_o = cmd.cmd_pkt.data;

  assign read_resp = io_resp_v_i & io_resp_read_i;

  assign cmd.cmd_yumi      = cmd_take;
  assign cmd.credits_empty = (credit_count_r == '0);
  assign cmd.read_done     = read_resp;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      credit_count_r <= '0;
    end
    else if (cmd_take && !io_resp_v_i)
    begin
      credit_count_r <= credit_count_r + 1'b1;
    end
    else if (!cmd_take && io_resp_v_i)
    begin
      credit_count_r <= credit_count_r - 1'b1;
    end
  end

  // Only one read is in flight, so a single expected slot is enough
  always_ff @(posedge clk_i)
  begin
    if (cmd_take && io_cmd_read_o)
    begin
      exp_data_r <= cmd.cmd_pkt.data;
      exp_size_r <= cmd.cmd_pkt.opcode.mem.size;
    end
  end

  always_comb
  begin
    unique case (exp_size_r)
      e_size_1: byte_mask = {{(`NBF_DATA_W-8){1'b0}}, {8{1'b1}}};
      e_size_2: byte_mask = {{(`NBF_DATA_W-16){1'b0}}, {16{1'b1}}};
      e_size_4: byte_mask = {{(`NBF_DATA_W-32){1'b0}}, {32{1'b1}}};
      default:  byte_mask = {`NBF_DATA_W{1'b1}};
    endcase
  end

  assign data_diff = |((io_resp_data_i ^ exp_data_r) & byte_mask);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      mismatch_count_r <= '0;
    end
    else if (read_resp && data_diff && (mismatch_count_r != 8'hFF))
    begin
      mismatch_count_r <= mismatch_count_r + 1'b1;  // Saturates
    end
  end

  assign mismatch_count_o = mismatch_count_r;

endmodule

//--- design/nbf_loader_top.sv
// Program loader top level joining packet buffer, sequencer and I/O port
`timescale 1ns/1ps
`include "nbf_loader_cfg.svh"

module nbf_loader_top
(
  input                               clk_i
  ,input                              reset_i

  ,input                              prog_we_i
  ,input        [`NBF_IDX_W-1:0]      prog_addr_i
  ,input        nbf_loader_pkg::nbf_packet_s prog_pkt_i
  ,input                              start_i

  ,input                              io_cmd_yumi_i
  ,input                              io_resp_v_i
  ,input                              io_resp_read_i
  ,input        [`NBF_DATA_W-1:0]     io_resp_data_i

  ,output logic                       io_cmd_v_o
  ,output logic                       io_cmd_read_o
  ,output       nbf_loader_pkg::nbf_size_e io_cmd_size_o
  ,output logic [`NBF_ADDR_W-1:0]     io_cmd_addr_o
  ,output logic [`NBF_DATA_W-1:0]     io_cmd_data_o
  ,output logic                       done_o
  ,output logic [7:0]                 mismatch_count_o
);

  import nbf_loader_pkg::*;

  logic [`NBF_IDX_W-1:0] pkt_idx;
  nbf_packet_s           cur_pkt;

  nbf_cmd_if cmd_if ();

  nbf_program_buffer u_buffer
  (
    .clk_i    (clk_i)
    ,.we_i    (prog_we_i)
    ,.waddr_i (prog_addr_i)
    ,.wpkt_i  (prog_pkt_i)
    ,.raddr_i (pkt_idx)
    ,.rpkt_o  (cur_pkt)
  );

  nbf_sequencer u_sequencer
  (
    .clk_i    (clk_i)
    ,.reset_i (reset_i)
    ,.start_i (start_i)
    ,.pkt_i   (cur_pkt)
    ,.idx_o   (pkt_idx)
    ,.done_o  (done_o)
    ,.cmd     (cmd_if.seq)
  );

  nbf_io_port u_io_port
  (
    .clk_i             (clk_i)
    ,.reset_i          (reset_i)
    ,.io_cmd_yumi_i    (io_cmd_yumi_i)
    ,.io_resp_v_i      (io_resp_v_i)
    ,.io_resp_read_i   (io_resp_read_i)
    ,.io_resp_data_i   (io_resp_data_i)
    ,.io_cmd_v_o       (io_cmd_v_o)
    ,.io_cmd_read_o    (io_cmd_read_o)
    ,.io_cmd_size_o    (io_cmd_size_o)
    ,.io_cmd_addr_o    (io_cmd_addr_o)
    ,.io_cmd_data_o    (io_cmd_data_o)
    ,.mismatch_count_o (mismatch_count_o)
    ,.cmd              (cmd_if.io)
  );

endmodule

//--- dv/nbf_loader_assert.sv
// Bound checks on credit limit, held commands and response timing at the I/O port
`timescale 1ns/1ps
`include "nbf_loader_cfg.svh"

module nbf_loader_assert
(
  input                               clk_i
  ,input                              reset_i
  ,input                              io_cmd_v_o
  ,input                              io_cmd_yumi_i
  ,input                              io_cmd_read_o
  ,input        nbf_loader_pkg::nbf_size_e io_cmd_size_o
  ,input        [`NBF_ADDR_W-1:0]     io_cmd_addr_o
  ,input        [`NBF_DATA_W-1:0]     io_cmd_data_o
  ,input                              io_resp_v_i
  ,input        [`NBF_CREDIT_W-1:0]   credit_count_r
);

  property credit_in_range;
    @(posedge clk_i) disable iff (reset_i)
      credit_count_r <= `NBF_MAX_CREDITS;
  endproperty

  // A waiting command stays on the bus unchanged
  property cmd_held;
    @(posedge clk_i) disable iff (reset_i)
      (io_cmd_v_o && !io_cmd_yumi_i) |=> (io_cmd_v_o && $stable(io_cmd_read_o)
        && $stable(io_cmd_size_o) && $stable(io_cmd_addr_o) && $stable(io_cmd_data_o));
  endproperty

  property resp_needs_credit;
    @(posedge clk_i) disable iff (reset_i)
      io_resp_v_i |-> (credit_count_r != '0);
  endproperty

  assert property (credit_in_range) else $error("Outstanding count above the credit limit");
  assert property (cmd_held) else $error("Command changed or dropped while waiting for yumi");
  assert property (resp_needs_credit) else $error("Response arrived with nothing outstanding");

endmodule

bind nbf_io_port nbf_loader_assert u_assert
(
  .clk_i           (clk_i)
  ,.reset_i        (reset_i)
  ,.io_cmd_v_o     (io_cmd_v_o)
  ,.io_cmd_yumi_i  (io_cmd_yumi_i)
  ,.io_cmd_read_o  (io_cmd_read_o)
  ,.io_cmd_size_o  (io_cmd_size_o)
  ,.io_cmd_addr_o  (io_cmd_addr_o)
  ,.io_cmd_data_o  (io_cmd_data_o)
  ,.io_resp_v_i    (io_resp_v_i)
  ,.credit_count_r (credit_count_r)
);

//--- dv/nbf_loader_tb.sv
// Loader testbench with random programs, a memory responder and a reference model
`timescale 1ns/1ps
`include "nbf_loader_cfg.svh"

module nbf_loader_tb;
  import nbf_loader_pkg::*;

  localparam int          IDX_W     = `NBF_IDX_W;
  localparam logic [31:0] ADDR_BASE = 32'h8000_0000;

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  logic                    prog_we_i;
  logic [`NBF_IDX_W-1:0]   prog_addr_i;
  nbf_packet_s             prog_pkt_i;
  logic                    start_i;
  logic                    io_cmd_yumi_i;
  logic                    io_resp_v_i;
  logic                    io_resp_read_i;
  logic [`NBF_DATA_W-1:0]  io_resp_data_i;
  logic                    io_cmd_v_o;
  logic                    io_cmd_read_o;
  nbf_size_e               io_cmd_size_o;
  logic [`NBF_ADDR_W-1:0]  io_cmd_addr_o;
  logic [`NBF_DATA_W-1:0]  io_cmd_data_o;
  logic                    done_o;
  logic [7:0]              mismatch_count_o;

  logic [31:0]  rng_state = 32'h88b7_3091;
  nbf_packet_s  prog [2][`NBF_DEPTH];
  int           prog_len [2];
  int           total_pkts = 0;
  nbf_packet_s  exp_cmds [$];   // Model's stores and reads in order
  bit           exp_drain [$];  // Command may only go out with nothing outstanding
  logic [7:0]   exp_mismatch;
  nbf_packet_s  pend_q [$];     // Responses still owed by the memory
  int           pend_due [$];
  logic [63:0]  mem_model [16];
  int           cyc = 0;
  int           outstanding = 0;
  int           yumi_wait = 0;
  nbf_packet_s  seen_cmd;
  nbf_packet_s  resp_cmd;
  bit           seen_drain;

  nbf_loader_top DUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [63:0] size_mask(input nbf_size_e size);
    case (size)
      e_size_1: return 64'h0000_0000_0000_00FF;
      e_size_2: return 64'h0000_0000_0000_FFFF;
      e_size_4: return 64'h0000_0000_FFFF_FFFF;
      default:  return 64'hFFFF_FFFF_FFFF_FFFF;
    endcase
  endfunction

  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_cmd(input logic rd, input nbf_size_e size,
                           input logic [`NBF_ADDR_W-1:0] addr,
                           input logic [`NBF_DATA_W-1:0] data, input nbf_packet_s exp);
    if (rd !== exp.opcode.mem.rd || size !== exp.opcode.mem.size
        || addr !== exp.addr || data !== exp.data)
    begin
      $display("FAILED at %0t: command rd=%0b size=%0d addr=%h data=%h", $time,
               rd, size, addr, data);
      $display("FAILED at %0t: expected rd=%0b size=%0d addr=%h data=%h", $time,
               exp.opcode.mem.rd, exp.opcode.mem.size, exp.addr, exp.data);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: mismatch_count_o is %0d, expected %0d", $time, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_idle();
    check_flag(io_cmd_v_o, 1'b0, "io_cmd_v_o");
    check_flag(done_o, 1'b0, "done_o");
    check_count(mismatch_count_o, 8'd0);
  endtask

  // Stores, reads of written slots and fences, closed by finish
  task automatic generate_program(input int p, input int corrupt_div);
    logic [63:0] gen_mem [16];
    bit          written [16];
    nbf_packet_s pkt;
    logic [31:0] r;
    logic [3:0]  slot;
    logic [63:0] mask;
    int          body;
    int          any_written;
    for (int s = 0; s < 16; s++)
    begin
      gen_mem[s] = '0;
      written[s] = 1'b0;
    end
    any_written = 0;
    body = 120 + int'(next_rand() % 79);
    for (int i = 0; i < body; i++)
    begin
      r = next_rand();
      pkt = '0;
      slot = r[6:3];
      if (r[2:0] == 3'd7)
      begin
        pkt.opcode.ctrl = `NBF_OP_FENCE;
        pkt.addr = next_rand();
      end
      else if (r[2] && any_written != 0)
      begin
        while (!written[slot])
          slot = slot + 4'd1;
        pkt.opcode.mem.rd = 1'b1;
        pkt.opcode.mem.size = nbf_size_e'(r[9:8]);
        pkt.addr = {ADDR_BASE[31:7], slot, 3'b000};
        mask = size_mask(pkt.opcode.mem.size);
        pkt.data = (gen_mem[slot] & mask) | ({next_rand(), next_rand()} & ~mask);
        if (corrupt_div != 0 && (next_rand() % corrupt_div) == 0)
          pkt.data = pkt.data ^ (64'd1 << (next_rand() % (8 << r[9:8])));  // Bad expected data
      end
      else
      begin
        pkt.opcode.mem.size = nbf_size_e'(r[9:8]);
        pkt.addr = {ADDR_BASE[31:7], slot, 3'b000};
        pkt.data = {next_rand(), next_rand()};
        gen_mem[slot] = pkt.data & size_mask(pkt.opcode.mem.size);
        written[slot] = 1'b1;
        any_written = 1;
      end
      prog[p][i] = pkt;
    end
    pkt = '0;
    pkt.opcode.ctrl = `NBF_OP_FINISH;
    prog[p][body] = pkt;
    prog_len[p] = body + 1;
  endtask

  // Reference walk of the program for the expected commands and mismatch count
  task automatic build_model(input int p);
    logic [63:0] shadow [16];
    nbf_packet_s pkt;
    logic [63:0] mask;
    bit          drain;
    for (int s = 0; s < 16; s++)
      shadow[s] = '0;
    exp_cmds.delete();
    exp_drain.delete();
    exp_mismatch = 8'd0;
    drain = 1'b0;
    for (int i = 0; i < prog_len[p]; i++)
    begin
      pkt = prog[p][i];
      if (pkt.opcode.ctrl == `NBF_OP_FINISH)
        break;
      if (pkt.opcode.ctrl == `NBF_OP_FENCE)
      begin
        drain = 1'b1;
        continue;
      end
      exp_cmds.push_back(pkt);
      exp_drain.push_back(drain);
      mask = size_mask(pkt.opcode.mem.size);
      drain = pkt.opcode.mem.rd;
      if (!pkt.opcode.mem.rd)
        shadow[pkt.addr[6:3]] = pkt.data & mask;
      else if (((pkt.data ^ shadow[pkt.addr[6:3]]) & mask) != '0 && exp_mismatch != 8'hFF)
        exp_mismatch = exp_mismatch + 8'd1;
    end
  endtask

  task automatic run_program(input int p);
    build_model(p);
    for (int s = 0; s < 16; s++)
      mem_model[s] = '0;
    @(posedge clk_i);
    #2;
    reset_i = 1'b1;
    repeat (5) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_idle();
    for (int i = 0; i < prog_len[p]; i++)
    begin
      @(posedge clk_i);
      #2;
      prog_we_i = 1'b1;
      prog_addr_i = IDX_W'(i);
      prog_pkt_i = prog[p][i];
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    #2;
    prog_we_i = 1'b0;
    start_i = 1'b1;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    @(negedge clk_i);
    while (!done_o)
      @(negedge clk_i);
    check_count(mismatch_count_o, exp_mismatch);
    while (pend_q.size() != 0)
      @(negedge clk_i);
    if (exp_cmds.size() != 0)
    begin
      $display("Program %0d finished with %0d commands never issued", p, exp_cmds.size());
      stop_with_failure();
    end
    check_flag(done_o, 1'b1, "done_o");
    check_count(mismatch_count_o, exp_mismatch);
  endtask

  // Memory responder driven 2 ns after the edge
  always @(posedge clk_i)
  begin
    #2;
    cyc = cyc + 1;
    if (pend_q.size() != 0 && pend_due[0] <= cyc)
    begin
      resp_cmd = pend_q.pop_front();
      void'(pend_due.pop_front());
      outstanding = outstanding - 1;
      if (!resp_cmd.opcode.mem.rd)
        mem_model[resp_cmd.addr[6:3]] = resp_cmd.data & size_mask(resp_cmd.opcode.mem.size);
      io_resp_v_i    = 1'b1;
      io_resp_read_i = resp_cmd.opcode.mem.rd;
      io_resp_data_i = resp_cmd.opcode.mem.rd ? mem_model[resp_cmd.addr[6:3]] : '0;
    end
    else
    begin
      io_resp_v_i    = 1'b0;
      io_resp_read_i = 1'b0;
      io_resp_data_i = '0;
    end
    if (io_cmd_v_o && yumi_wait == 0)
    begin
      io_cmd_yumi_i = 1'b1;
      yumi_wait = int'(next_rand() % 4);  // Stall before the next take
    end
    else
    begin
      io_cmd_yumi_i = 1'b0;
      if (io_cmd_v_o)
        yumi_wait = yumi_wait - 1;
    end
  end

  // Command taken at the coming edge
  always @(negedge clk_i)
  begin
    if (io_cmd_v_o && io_cmd_yumi_i)
    begin
      if (exp_cmds.size() == 0)
      begin
        $display("A command was issued that the program does not contain");
        stop_with_failure();
      end
      seen_drain = exp_drain.pop_front();
      check_cmd(io_cmd_read_o, io_cmd_size_o, io_cmd_addr_o, io_cmd_data_o,
                exp_cmds.pop_front());
      if (seen_drain && outstanding != 0)
      begin
        $display("A command went out after a fence or read with responses still owed");
        stop_with_failure();
      end
      seen_cmd = '0;
      seen_cmd.opcode.mem.rd = io_cmd_read_o;
      seen_cmd.opcode.mem.size = io_cmd_size_o;
      seen_cmd.addr = io_cmd_addr_o;
      seen_cmd.data = io_cmd_data_o;
      pend_q.push_back(seen_cmd);
      pend_due.push_back(cyc + 1 + int'(next_rand() % 6));
      outstanding = outstanding + 1;
      if (outstanding > `NBF_MAX_CREDITS)
      begin
        $display("More commands outstanding than the credit limit allows");
        stop_with_failure();
      end
    end
  end

  initial
  begin
    wait (total_pkts != 0);
    repeat (40 * total_pkts + 1000) @(posedge clk_i);
    $display("Timeout: the loader did not finish both programs in time");
    stop_with_failure();
  end

  initial
  begin
    reset_i        = 1'b1;
    prog_we_i      = 1'b0;
    prog_addr_i    = '0;
    prog_pkt_i     = '0;
    start_i        = 1'b0;
    io_cmd_yumi_i  = 1'b0;
    io_resp_v_i    = 1'b0;
    io_resp_read_i = 1'b0;
    io_resp_data_i = '0;
    generate_program(0, 0);  // Clean reads only
    generate_program(1, 4);  // About one read in four corrupted
    total_pkts = prog_len[0] + prog_len[1];
    run_program(0);
    run_program(1);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- nbf_loader.f
+incdir+design
design/nbf_loader_pkg.sv
design/nbf_cmd_if.sv
design/nbf_program_buffer.sv
design/nbf_sequencer.sv
design/nbf_io_port.sv
design/nbf_loader_top.sv
dv/nbf_loader_assert.sv
dv/nbf_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the loader testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module nbf_loader_tb -f nbf_loader.f -o nbf_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/nbf_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
